/* hw/rv_pkg.sv */
// shared rv64 types; the union assumes standard little-end field order in a 32-bit word.
`default_nettype none

package rv_pkg;

  localparam int XLEN = 64;

  // opcodes of the supported subset.
  localparam logic [6:0] OP_IMM = 7'b0010011;
  localparam logic [6:0] OP     = 7'b0110011;
  localparam logic [6:0] LUI    = 7'b0110111;
  localparam logic [6:0] AUIPC  = 7'b0010111;
  localparam logic [6:0] JAL    = 7'b1101111;
  localparam logic [6:0] SYSTEM = 7'b1110011;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } rv_fmt_r_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } rv_fmt_i_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    logic [6:0] opcode;
  } rv_fmt_s_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } rv_fmt_b_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } rv_fmt_u_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } rv_fmt_j_t;

  // one fetched word, read in any of the six formats.
  typedef union packed {
    rv_fmt_r_t fmt_r;
    rv_fmt_i_t fmt_i;
    rv_fmt_s_t fmt_s;
    rv_fmt_b_t fmt_b;
    rv_fmt_u_t fmt_u;
    rv_fmt_j_t fmt_j;
  } rv_inst_t;

  typedef enum logic [2:0] {
    IMM_I = 3'b000,
    IMM_U = 3'b001,
    IMM_S = 3'b010,
    IMM_B = 3'b011,
    IMM_J = 3'b100
  } rv_imm_sel_e;

  typedef enum logic [3:0] {
    ALU_ADD    = 4'b0000,
    ALU_COPY_B = 4'b0001,
    ALU_HALT   = 4'b1111 // ebreak.
  } rv_alu_op_e;

endpackage

`default_nettype wire

/* hw/rv_dec_if.sv */
// decoded control bundle; all members are combinational levels valid for the whole cycle.
`timescale 1ns/1ps
`default_nettype none

interface rv_dec_if import rv_pkg::*; ();

  logic [XLEN-1:0] imm;
  logic [4:0]      ra;
  logic [4:0]      rb;
  logic [4:0]      rd;
  logic            wen;
  logic            a_src_pc;  // operand a from pc.
  logic            b_src_imm; // operand b from imm.
  rv_alu_op_e      alu_op;
  logic            is_jal;
  logic            is_ebreak;

  modport decoder (
    output imm, ra, rb, rd, wen, a_src_pc, b_src_imm, alu_op, is_jal, is_ebreak
  );

  modport execute (
    input imm, a_src_pc, b_src_imm, alu_op, is_jal
  );

  modport writeback (
    input rd, wen, is_jal, is_ebreak
  );

endinterface

`default_nettype wire

/* hw/rv_ifu.sv */
// pc and instruction memory; loads only while reset is held, IMEM_WORDS must be a power of two.
`timescale 1ns/1ps
`default_nettype none

module rv_ifu import rv_pkg::*; #(
  parameter logic [XLEN-1:0] RESET_PC   = 64'h8000_0000,
  parameter int              IMEM_WORDS = 256
) (
  input  wire logic                          i_clk,
  input  wire logic                          i_reset,
  input  wire logic                          i_imem_we,
  input  wire logic [$clog2(IMEM_WORDS)-1:0] i_imem_addr,
  input  wire logic [31:0]                   i_imem_wdata,
  input  wire logic [XLEN-1:0]               i_next_pc,
  input  wire logic                          i_stall,
  output logic [XLEN-1:0]                    o_pc,
  output rv_inst_t                           o_inst
);

  localparam int AW = $clog2(IMEM_WORDS);

  logic [31:0]     imem [IMEM_WORDS];
  logic [XLEN-1:0] pc_q;
  logic [XLEN-1:0] pc_off;
  logic [AW-1:0]   rd_idx;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      pc_q <= RESET_PC;
    end else if (!i_stall) begin
      pc_q <= i_next_pc;
    end
  end

  // program load.
  always_ff @(posedge i_clk) begin
    if (i_reset && i_imem_we) begin
      imem[i_imem_addr] <= i_imem_wdata;
    end
  end

  // word index, wraps on the index width.
  assign pc_off = pc_q - RESET_PC;
  assign rd_idx = pc_off[AW+1:2];

  assign o_pc   = pc_q;
  assign o_inst = imem[rd_idx];

endmodule

`default_nettype wire

/* hw/rv_idu.sv */
// decoder for addi, add, lui, auipc, jal and ebreak; any other word decodes as a no-op.
`timescale 1ns/1ps
`default_nettype none

module rv_idu import rv_pkg::*; (
  input  rv_inst_t         i_inst,
  rv_dec_if.decoder        dec
);

  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_s;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_j;
  logic            inst_addi;
  logic            inst_add;
  logic            inst_lui;
  logic            inst_auipc;
  logic            inst_jal;
  logic            inst_ebreak;
  logic            type_r;
  logic            type_i;
  logic            type_u;
  logic            type_j;
  logic [3:0]      inst_type;
  rv_imm_sel_e     imm_sel;

  assign opcode = i_inst.fmt_r.opcode;
  assign funct3 = i_inst.fmt_r.funct3;
  assign funct7 = i_inst.fmt_r.funct7;

  assign dec.ra = i_inst.fmt_r.rs1;
  assign dec.rb = i_inst.fmt_r.rs2;
  assign dec.rd = i_inst.fmt_r.rd;

  // immediates, all sign-extended from bit 31.
  assign imm_i = {{52{i_inst.fmt_i.imm_11_0[11]}}, i_inst.fmt_i.imm_11_0};
  assign imm_u = {{32{i_inst.fmt_u.imm_31_12[19]}}, i_inst.fmt_u.imm_31_12, 12'b0};
  assign imm_s = {{52{i_inst.fmt_s.imm_11_5[6]}}, i_inst.fmt_s.imm_11_5,
                  i_inst.fmt_s.imm_4_0};
  assign imm_b = {{51{i_inst.fmt_b.imm_12}}, i_inst.fmt_b.imm_12, i_inst.fmt_b.imm_11,
                  i_inst.fmt_b.imm_10_5, i_inst.fmt_b.imm_4_1, 1'b0};
  assign imm_j = {{43{i_inst.fmt_j.imm_20}}, i_inst.fmt_j.imm_20, i_inst.fmt_j.imm_19_12,
                  i_inst.fmt_j.imm_11, i_inst.fmt_j.imm_10_1, 1'b0};

  assign inst_addi   = (opcode == OP_IMM) && (funct3 == 3'b000);
  assign inst_add    = (opcode == OP) && (funct3 == 3'b000) && (funct7 == 7'b0);
  assign inst_lui    = (opcode == LUI);
  assign inst_auipc  = (opcode == AUIPC);
  assign inst_jal    = (opcode == JAL);
  assign inst_ebreak = (opcode == SYSTEM) && (i_inst.fmt_i.imm_11_0 == 12'h001);

  assign type_r = inst_add;
  assign type_i = inst_addi | inst_ebreak;
  assign type_u = inst_lui | inst_auipc;
  assign type_j = inst_jal;

  assign inst_type = {type_r, type_i, type_u, type_j};

  always_comb begin
    case (inst_type)
      4'b0010: imm_sel = IMM_U;
      4'b0001: imm_sel = IMM_J;
      default: imm_sel = IMM_I; // r-type ignores imm.
    endcase
  end

  always_comb begin
    case (imm_sel)
      IMM_I:   dec.imm = imm_i;
      IMM_U:   dec.imm = imm_u;
      IMM_S:   dec.imm = imm_s;
      IMM_B:   dec.imm = imm_b;
      IMM_J:   dec.imm = imm_j;
      default: dec.imm = '0;
    endcase
  end

  // ebreak is i-type but writes nothing.
  assign dec.wen       = |{inst_add, inst_addi, inst_lui, inst_auipc, inst_jal};
  assign dec.a_src_pc  = inst_auipc | inst_jal;
  assign dec.b_src_imm = |{type_i, type_u, type_j};
  assign dec.is_jal    = inst_jal;
  assign dec.is_ebreak = inst_ebreak;

  always_comb begin
    if (inst_ebreak) begin
      dec.alu_op = ALU_HALT;
    end else if (inst_lui) begin
      dec.alu_op = ALU_COPY_B;
    end else begin
      dec.alu_op = ALU_ADD;
    end
  end

endmodule

`default_nettype wire

/* hw/rv_regfile.sv */
// 32 x XLEN register file, async reads, x0 never written so it reads zero after reset.
`timescale 1ns/1ps
`default_nettype none

module rv_regfile import rv_pkg::*; (
  input  wire logic            i_clk,
  input  wire logic            i_reset,
  input  wire logic [4:0]      i_ra,
  input  wire logic [4:0]      i_rb,
  input  wire logic            i_we,
  input  wire logic [4:0]      i_wa,
  input  wire logic [XLEN-1:0] i_wdata,
  output logic [XLEN-1:0]      o_rdata_a,
  output logic [XLEN-1:0]      o_rdata_b
);

  logic [XLEN-1:0] regs [32];

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we && (i_wa != 5'd0)) begin
      regs[i_wa] <= i_wdata;
    end
  end

  assign o_rdata_a = regs[i_ra];
  assign o_rdata_b = regs[i_rb];

endmodule

`default_nettype wire

/* hw/rv_exu.sv */
// operand select, add/copy alu and next pc; no branches, only jal redirects.
`timescale 1ns/1ps
`default_nettype none

module rv_exu import rv_pkg::*; (
  input  wire logic [XLEN-1:0] i_pc,
  input  wire logic [XLEN-1:0] i_rdata_a,
  input  wire logic [XLEN-1:0] i_rdata_b,
  rv_dec_if.execute            dec,
  output logic [XLEN-1:0]      o_alu_result,
  output logic [XLEN-1:0]      o_next_pc
);

  logic [XLEN-1:0] op_a;
  logic [XLEN-1:0] op_b;
  logic [XLEN-1:0] sum;

  assign op_a = dec.a_src_pc ? i_pc : i_rdata_a;
  assign op_b = dec.b_src_imm ? dec.imm : i_rdata_b;
  assign sum  = op_a + op_b;

  always_comb begin
    case (dec.alu_op)
      ALU_ADD:    o_alu_result = sum;
      ALU_COPY_B: o_alu_result = op_b; // lui.
      ALU_HALT:   o_alu_result = '0;
      default:    o_alu_result = '0;
    endcase
  end

  // jal target is pc + immJ from the adder.
  assign o_next_pc = dec.is_jal ? sum : i_pc + 64'd4;

endmodule

`default_nettype wire

/* hw/rv_wbu.sv */
// writeback and commit report; nothing commits while reset is held nor after ebreak.
`timescale 1ns/1ps
`default_nettype none

module rv_wbu import rv_pkg::*; (
  input  wire logic            i_clk,
  input  wire logic            i_reset,
  input  wire logic [XLEN-1:0] i_pc,
  input  rv_inst_t             i_inst,
  input  wire logic [XLEN-1:0] i_alu_result,
  rv_dec_if.writeback          dec,
  output logic                 o_rf_we,
  output logic [4:0]           o_rf_wa,
  output logic [XLEN-1:0]      o_rf_wdata,
  output logic                 o_stall,
  output logic                 o_commit_valid,
  output logic [31:0]          o_commit_inst,
  output logic [4:0]           o_commit_rd,
  output logic                 o_commit_wen,
  output logic [XLEN-1:0]      o_commit_wdata,
  output logic                 o_halt
);

  logic            halt_q;
  logic            commit;
  logic [XLEN-1:0] wdata;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      halt_q <= 1'b0;
    end else if (commit && dec.is_ebreak) begin
      halt_q <= 1'b1;
    end
  end

  assign commit = ~i_reset & ~halt_q;
  assign wdata  = dec.is_jal ? i_pc + 64'd4 : i_alu_result; // link address for jal.

  assign o_rf_we    = commit & dec.wen;
  assign o_rf_wa    = dec.rd;
  assign o_rf_wdata = wdata;
  assign o_stall    = halt_q;

  assign o_commit_valid = commit;
  assign o_commit_inst  = i_inst;
  assign o_commit_rd    = dec.rd;
  assign o_commit_wen   = dec.wen;
  assign o_commit_wdata = wdata;
  assign o_halt         = halt_q;

endmodule

`default_nettype wire

/* hw/rv_core.sv */
// single-cycle rv64 core top; imem is loadable only during reset, halts for good on ebreak.
`timescale 1ns/1ps
`default_nettype none

module rv_core import rv_pkg::*; #(
  parameter logic [XLEN-1:0] RESET_PC   = 64'h8000_0000,
  parameter int              IMEM_WORDS = 256
) (
  input  wire logic                          i_clk,
  input  wire logic                          i_reset,
  input  wire logic                          i_imem_we,
  input  wire logic [$clog2(IMEM_WORDS)-1:0] i_imem_addr,
  input  wire logic [31:0]                   i_imem_wdata,
  output logic [XLEN-1:0]                    o_pc,
  output logic                               o_commit_valid,
  output logic [31:0]                        o_commit_inst,
  output logic [4:0]                         o_commit_rd,
  output logic                               o_commit_wen,
  output logic [XLEN-1:0]                    o_commit_wdata,
  output logic                               o_halt
);

  rv_inst_t        inst;
  logic [XLEN-1:0] next_pc;
  logic            stall;
  logic [XLEN-1:0] rdata_a;
  logic [XLEN-1:0] rdata_b;
  logic [XLEN-1:0] alu_result;
  logic            rf_we;
  logic [4:0]      rf_wa;
  logic [XLEN-1:0] rf_wdata;

  rv_dec_if dec ();

  rv_ifu #(
    .RESET_PC   (RESET_PC),
    .IMEM_WORDS (IMEM_WORDS)
  ) ifu_i (
    .i_clk        (i_clk),
    .i_reset      (i_reset),
    .i_imem_we    (i_imem_we),
    .i_imem_addr  (i_imem_addr),
    .i_imem_wdata (i_imem_wdata),
    .i_next_pc    (next_pc),
    .i_stall      (stall),
    .o_pc         (o_pc),
    .o_inst       (inst)
  );

  rv_idu idu_i (
    .i_inst (inst),
    .dec    (dec.decoder)
  );

  rv_regfile regfile_i (
    .i_clk     (i_clk),
    .i_reset   (i_reset),
    .i_ra      (dec.ra),
    .i_rb      (dec.rb),
    .i_we      (rf_we),
    .i_wa      (rf_wa),
    .i_wdata   (rf_wdata),
    .o_rdata_a (rdata_a),
    .o_rdata_b (rdata_b)
  );

  rv_exu exu_i (
    .i_pc         (o_pc),
    .i_rdata_a    (rdata_a),
    .i_rdata_b    (rdata_b),
    .dec          (dec.execute),
    .o_alu_result (alu_result),
    .o_next_pc    (next_pc)
  );

  rv_wbu wbu_i (
    .i_clk          (i_clk),
    .i_reset        (i_reset),
    .i_pc           (o_pc),
    .i_inst         (inst),
    .i_alu_result   (alu_result),
    .dec            (dec.writeback),
    .o_rf_we        (rf_we),
    .o_rf_wa        (rf_wa),
    .o_rf_wdata     (rf_wdata),
    .o_stall        (stall),
    .o_commit_valid (o_commit_valid),
    .o_commit_inst  (o_commit_inst),
    .o_commit_rd    (o_commit_rd),
    .o_commit_wen   (o_commit_wen),
    .o_commit_wdata (o_commit_wdata),
    .o_halt         (o_halt)
  );

endmodule

`default_nettype wire

/* verification/rv_model.svh */
// golden model and encoders; included inside the testbench module, assumes a 256-word program.
`ifndef RV_MODEL_SVH
`define RV_MODEL_SVH

localparam logic [31:0] EBREAK_WORD = 32'h0010_0073;

logic [31:0] lfsr_q = 32'haade_58a6;
logic [31:0] prog_mem [256];
logic [63:0] model_regs [32];
logic [63:0] model_pc;
logic [63:0] model_base;
logic        model_halted;
logic        exp_wen;
logic [4:0]  exp_rd;
logic [63:0] exp_wdata;

// fibonacci, taps 32 22 2 1.
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

function automatic logic [31:0] take_bits(input int n);
  logic [31:0] bits;
  bits = '0;
  for (int i = 0; i < n; i++) begin
    lfsr_q = lfsr_next(lfsr_q);
    bits   = {bits[30:0], lfsr_q[0]};
  end
  return bits;
endfunction

function automatic logic [31:0] enc_addi(input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [11:0] imm);
  return {imm, rs1, 3'b000, rd, OP_IMM};
endfunction

function automatic logic [31:0] enc_add(input logic [4:0] rd, input logic [4:0] rs1,
                                        input logic [4:0] rs2);
  return {7'b0, rs2, rs1, 3'b000, rd, OP};
endfunction

function automatic logic [31:0] enc_u(input logic [6:0] op, input logic [4:0] rd,
                                      input logic [19:0] imm);
  return {imm, rd, op};
endfunction

function automatic logic [31:0] enc_jal(input logic [4:0] rd, input logic [20:0] off);
  return {off[20], off[10:1], off[11], off[19:12], rd, JAL};
endfunction

function automatic logic [31:0] random_inst(input logic to_x0);
  logic [1:0]  kind;
  logic [4:0]  rd;
  logic [31:0] w;
  kind = 2'(take_bits(2));
  rd   = to_x0 ? 5'd0 : 5'(take_bits(5));
  case (kind)
    2'd0:    w = enc_addi(rd, 5'(take_bits(5)), 12'(take_bits(12)));
    2'd1:    w = enc_add(rd, 5'(take_bits(5)), 5'(take_bits(5)));
    2'd2:    w = enc_u(LUI, rd, 20'(take_bits(20)));
    default: w = enc_u(AUIPC, rd, 20'(take_bits(20)));
  endcase
  return w;
endfunction

function automatic void model_reset(input logic [63:0] base);
  model_base   = base;
  model_pc     = base;
  model_halted = 1'b0;
  for (int r = 0; r < 32; r++) begin
    model_regs[r] = '0;
  end
endfunction

function automatic logic [31:0] model_fetch();
  logic [63:0] off;
  off = model_pc - model_base;
  return prog_mem[off[9:2]];
endfunction

// one retired instruction, isa rules for the subset.
function automatic void model_step(input logic [31:0] w);
  logic [63:0] imm_i;
  logic [63:0] imm_u;
  logic [63:0] imm_j;
  logic [63:0] next_pc;
  imm_i     = {{52{w[31]}}, w[31:20]};
  imm_u     = {{32{w[31]}}, w[31:12], 12'h000};
  imm_j     = {{44{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
  next_pc   = model_pc + 64'd4;
  exp_rd    = w[11:7];
  exp_wen   = 1'b1;
  exp_wdata = '0;
  if (w[6:0] == OP_IMM && w[14:12] == 3'b000) begin
    exp_wdata = model_regs[w[19:15]] + imm_i;
  end else if (w[6:0] == OP && w[14:12] == 3'b000 && w[31:25] == 7'b0) begin
    exp_wdata = model_regs[w[19:15]] + model_regs[w[24:20]];
  end else if (w[6:0] == LUI) begin
    exp_wdata = imm_u;
  end else if (w[6:0] == AUIPC) begin
    exp_wdata = model_pc + imm_u;
  end else if (w[6:0] == JAL) begin
    exp_wdata = model_pc + 64'd4; // link.
    next_pc   = model_pc + imm_j;
  end else begin
    exp_wen      = 1'b0;
    model_halted = (w == EBREAK_WORD);
  end
  if (exp_wen && exp_rd != 5'd0) begin
    model_regs[exp_rd] = exp_wdata;
  end
  model_pc = next_pc;
endfunction

`endif

/* verification/rv_core_tb.sv */
// testbench for rv_core; reset covers the program load and then five more cycles.
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb import rv_pkg::*; ();

  localparam logic [63:0] RESET_PC     = 64'h8000_0000;
  localparam int          IMEM_WORDS   = 256;
  localparam int          RESET_CYCLES = 5;
  localparam int          MAX_CYCLES   = 200; // ~66 commits, 10 halted cycles, margin.

  logic        i_clk;
  logic        i_reset;
  logic        i_imem_we;
  logic [7:0]  i_imem_addr;
  logic [31:0] i_imem_wdata;
  logic [63:0] o_pc;
  logic        o_commit_valid;
  logic [31:0] o_commit_inst;
  logic [4:0]  o_commit_rd;
  logic        o_commit_wen;
  logic [63:0] o_commit_wdata;
  logic        o_halt;
  logic [31:0] prog_q [$];
  int          cycles;

  `include "rv_model.svh"

  rv_core #(
    .RESET_PC   (RESET_PC),
    .IMEM_WORDS (IMEM_WORDS)
  ) rv_core_i (.*);

  always #4 i_clk = ~i_clk;

  task automatic abort_run();
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
    $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
    abort_run();
  endtask

  task automatic report_error(input string what);
    $display("%s", what);
    abort_run();
  endtask

  // forward jump over offset/4-1 words that never run.
  task automatic add_jal(input int offset);
    prog_q.push_back(enc_jal(5'(take_bits(5)), 21'(offset)));
    for (int f = 1; f < offset / 4; f++) begin
      prog_q.push_back(random_inst(1'b0));
    end
  endtask

  task automatic build_program();
    for (int k = 0; k < 60; k++) begin
      if (k == 20 || k == 40) begin
        add_jal(k / 20 * 8);
      end
      if (k % 20 == 5) begin
        prog_q.push_back(random_inst(1'b1));
        prog_q.push_back(enc_add(5'(take_bits(5)) | 5'd1, 5'd0, 5'd0)); // reads x0.
      end else begin
        prog_q.push_back(random_inst(1'b0));
      end
    end
    prog_q.push_back(EBREAK_WORD);
  endtask

  // commit checks against the model, mid-cycle.
  always @(negedge i_clk) begin
    if (!i_reset) begin
      assert (o_halt == model_halted)
        else report_mismatch("o_halt", 64'(o_halt), 64'(model_halted));
      if (model_halted) begin
        assert (!o_commit_valid) else report_error("commit reported after the core halted.");
        assert (o_pc == model_pc) else report_mismatch("o_pc", o_pc, model_pc);
      end else begin
        assert (o_commit_valid) else report_error("running core skipped a commit.");
        assert (o_pc == model_pc) else report_mismatch("o_pc", o_pc, model_pc);
        assert (o_commit_inst == model_fetch())
          else report_mismatch("o_commit_inst", 64'(o_commit_inst), 64'(model_fetch()));
        model_step(o_commit_inst);
        assert (o_commit_rd == exp_rd)
          else report_mismatch("o_commit_rd", 64'(o_commit_rd), 64'(exp_rd));
        assert (o_commit_wen == exp_wen)
          else report_mismatch("o_commit_wen", 64'(o_commit_wen), 64'(exp_wen));
        assert (!exp_wen || o_commit_wdata == exp_wdata)
          else report_mismatch("o_commit_wdata", o_commit_wdata, exp_wdata);
      end
    end
  end

  always @(posedge i_clk) begin
    if (!i_reset) begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES) begin
        report_error("timeout: the core never halted.");
      end
    end
  end

  initial begin
    i_clk        = 1'b0;
    i_reset      = 1'b1;
    i_imem_we    = 1'b0;
    i_imem_addr  = '0;
    i_imem_wdata = '0;
    cycles       = 0;
    model_reset(RESET_PC);
    build_program();
    for (int a = 0; a < prog_q.size(); a++) begin
      @(posedge i_clk);
      #1;
      i_imem_we    = 1'b1;
      i_imem_addr  = 8'(a);
      i_imem_wdata = prog_q[a];
      prog_mem[a]  = prog_q[a];
    end
    @(posedge i_clk);
    #1;
    i_imem_we = 1'b0;
    repeat (RESET_CYCLES - 1) @(posedge i_clk);
    #1;
    i_reset = 1'b0;
    @(negedge i_clk);
    assert (o_pc == RESET_PC) else report_mismatch("o_pc", o_pc, RESET_PC);
    while (!o_halt) begin
      @(posedge i_clk);
    end
    repeat (10) @(posedge i_clk); // halted cycles are checked above.
    @(negedge i_clk);
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
+incdir+verification
hw/rv_pkg.sv
hw/rv_dec_if.sv
hw/rv_ifu.sv
hw/rv_idu.sv
hw/rv_regfile.sv
hw/rv_exu.sv
hw/rv_wbu.sv
hw/rv_core.sv
verification/rv_core_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build with verilator, run, and look for the pass line in the output.
cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/1ps -f list.f --top-module rv_core_tb &&
./obj_dir/Vrv_core_tb | tee /dev/stderr | grep -F "Simulation finished: PASS" > /dev/null &&
echo "run passed" ||
{ echo "run failed"; exit 1; }
